// ==== hw/line_defs.svh ====
`ifndef LINE_DEFS_SVH
`define LINE_DEFS_SVH

// screen coordinates, 1024 x 1024 frame
`define COORD_W 10

// signed difference of two coordinates
// also the base width of the Bresenham error term
`define DELTA_W 11

`endif

// ==== hw/line_pkg.sv ====
`include "line_defs.svh"

package line_pkg;

  // endpoint as the client sees it
  typedef struct packed {
    logic [`COORD_W-1:0] x;
    logic [`COORD_W-1:0] y;
  } screen_pt_t;

  // endpoint after normalization, major axis always counts up
  typedef struct packed {
    logic [`COORD_W-1:0] major;
    logic [`COORD_W-1:0] minor;
  } norm_pt_t;

  // the swapper fills in x/y, the stepper reads major/minor
  typedef union packed {
    screen_pt_t scr;
    norm_pt_t   norm;
  } seg_pt_u;

  // octant class, decoded in full by the swapper
  typedef struct packed {
    logic steep;
    logic negative;
    logic reversed;
  } octant_t;

endpackage

// ==== hw/line_seg_if.sv ====
interface line_seg_if import line_pkg::*; ();

  // one-cycle strobe, fields below only valid with it
  logic    load;
  // normalized endpoints, p0 holds the smaller major coordinate
  seg_pt_u p0;
  seg_pt_u p1;
  // minor coordinate walks downward
  logic    negative;
  octant_t octant;
  // stepper is drawing, setup holds off new lines
  logic    busy;

  modport source (
    output load, p0, p1, negative, octant,
    input  busy
  );

  modport sink (
    input  load, p0, p1, negative, octant,
    output busy
  );

endinterface

// ==== hw/point_swapper.sv ====
module point_swapper import line_pkg::*; (
  input  seg_pt_u [1:0] pts,
  input  octant_t       octant,
  output seg_pt_u       sp0,
  output seg_pt_u       sp1
);

  // outputs are written in the screen view
  // x ends up on the major axis so the stepper sees it as major
  always_comb begin
    case (octant)
      3'b000: begin
        // shallow rising line drawn left to right, nothing to do
        sp0.scr = pts[0].scr;
        sp1.scr = pts[1].scr;
      end
      3'b001: begin
        // shallow rising, right to left
        // trade the endpoints
        sp0.scr = pts[1].scr;
        sp1.scr = pts[0].scr;
      end
      3'b010: begin
        // shallow falling left to right
        // slope sign handled by the stepper
        sp0.scr = pts[0].scr;
        sp1.scr = pts[1].scr;
      end
      3'b011: begin
        // shallow falling, right to left
        sp0.scr = pts[1].scr;
        sp1.scr = pts[0].scr;
      end
      3'b100: begin
        // steep rising, y already counts up
        // exchange x and y in both points
        sp0.scr = '{x: pts[0].scr.y, y: pts[0].scr.x};
        sp1.scr = '{x: pts[1].scr.y, y: pts[1].scr.x};
      end
      3'b101: begin
        // steep rising but y counts down
        // exchange axes and endpoints
        sp0.scr = '{x: pts[1].scr.y, y: pts[1].scr.x};
        sp1.scr = '{x: pts[0].scr.y, y: pts[0].scr.x};
      end
      3'b110: begin
        // steep falling with y counting up
        sp0.scr = '{x: pts[0].scr.y, y: pts[0].scr.x};
        sp1.scr = '{x: pts[1].scr.y, y: pts[1].scr.x};
      end
      3'b111: begin
        // steep falling, y counts down
        sp0.scr = '{x: pts[1].scr.y, y: pts[1].scr.x};
        sp1.scr = '{x: pts[0].scr.y, y: pts[0].scr.x};
      end
      default: begin
        sp0.scr = pts[0].scr;
        sp1.scr = pts[1].scr;
      end
    endcase
  end

  // reversed flag from setup must leave the major axis counting upward
  always_comb begin
    a_major_ordered: assert final ($isunknown({sp0, sp1}) ||
                                   sp0.norm.major <= sp1.norm.major)
      else $error("normalized endpoints out of order on major axis");
  end

endmodule

// ==== hw/line_setup.sv ====
`include "line_defs.svh"

module line_setup import line_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic [`COORD_W-1:0] x0,
  input  logic [`COORD_W-1:0] y0,
  input  logic [`COORD_W-1:0] x1,
  input  logic [`COORD_W-1:0] y1,
  line_seg_if.source          seg
);

  logic [`COORD_W-1:0] x0_q;
  logic [`COORD_W-1:0] y0_q;
  logic [`COORD_W-1:0] x1_q;
  logic [`COORD_W-1:0] y1_q;
  logic                load_q;
  logic                accept;
  logic [`DELTA_W-1:0] dx;
  logic [`DELTA_W-1:0] dy;
  logic [`COORD_W-1:0] adx;
  logic [`COORD_W-1:0] ady;
  logic                steep;
  logic                reversed;
  logic                negative;
  octant_t             octant;
  seg_pt_u [1:0]       pts;
  seg_pt_u             sp0;
  seg_pt_u             sp1;

  // busy only rises after load, so the load cycle itself must also block
  assign accept = start && !seg.busy && !load_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      load_q <= 1'b0;
    end else begin
      load_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      x0_q <= x0;
      y0_q <= y0;
      x1_q <= x1;
      y1_q <= y1;
    end
  end

  // signed deltas and their magnitudes
  assign dx  = {1'b0, x1_q} - {1'b0, x0_q};
  assign dy  = {1'b0, y1_q} - {1'b0, y0_q};
  assign adx = dx[`DELTA_W-1] ? x0_q - x1_q : x1_q - x0_q;
  assign ady = dy[`DELTA_W-1] ? y0_q - y1_q : y1_q - y0_q;

  // ties go to the shallow side, diagonals step along x
  assign steep    = ady > adx;
  assign reversed = steep ? (y0_q > y1_q) : (x0_q > x1_q);
  // with a zero delta the minor axis never moves, so the sign is moot
  assign negative = dx[`DELTA_W-1] != dy[`DELTA_W-1];
  assign octant   = '{steep: steep, negative: negative, reversed: reversed};

  assign pts[0].scr = '{x: x0_q, y: y0_q};
  assign pts[1].scr = '{x: x1_q, y: y1_q};

  point_swapper u_swapper (
    .pts    (pts),
    .octant (octant),
    .sp0    (sp0),
    .sp1    (sp1)
  );

  assign seg.load     = load_q;
  assign seg.p0       = sp0;
  assign seg.p1       = sp1;
  assign seg.negative = negative;
  assign seg.octant   = octant;

  // stepper busy must have blocked any second start
  a_no_load_busy: assert property (@(posedge clk) disable iff (rst)
    !(seg.load && seg.busy))
    else $error("segment loaded while stepper busy");

endmodule

// ==== hw/bresenham_stepper.sv ====
`include "line_defs.svh"

module bresenham_stepper import line_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  line_seg_if.sink            seg,
  output logic                pixel_valid,
  output logic [`COORD_W-1:0] pixel_x,
  output logic [`COORD_W-1:0] pixel_y,
  output logic                done
);

  // current position in normalized space
  norm_pt_t            cur_q;
  logic [`COORD_W-1:0] end_major_q;
  logic [`DELTA_W-1:0] dmaj_q;
  logic [`DELTA_W-1:0] dmin_q;
  // error spans roughly -2*dmaj to 2*dmin with one bit over the delta width
  logic [`DELTA_W:0]   err_q;
  logic                neg_q;
  logic                steep_q;
  logic                stepping_q;
  logic                busy_q;

  logic [`DELTA_W-1:0] dmaj_in;
  logic [`DELTA_W-1:0] dmin_in;
  logic [`DELTA_W:0]   err_in;
  logic                last;
  logic                err_pos;

  // major delta never negative in a normalized line
  assign dmaj_in = {1'b0, seg.p1.norm.major - seg.p0.norm.major};
  // minor delta as a magnitude
  // direction kept apart in neg_q
  assign dmin_in = seg.negative ? {1'b0, seg.p0.norm.minor - seg.p1.norm.minor}
                                : {1'b0, seg.p1.norm.minor - seg.p0.norm.minor};
  // initial decision term 2*dmin - dmaj
  assign err_in  = {dmin_in, 1'b0} - {1'b0, dmaj_in};

  assign last    = cur_q.major == end_major_q;
  assign err_pos = !err_q[`DELTA_W];

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      stepping_q  <= 1'b0;
      busy_q      <= 1'b0;
      pixel_valid <= 1'b0;
      done        <= 1'b0;
    end else begin
      // held through the cycle of the last pixel
      busy_q      <= seg.load || stepping_q;
      pixel_valid <= stepping_q;
      done        <= stepping_q && last;
      if (seg.load) begin
        stepping_q <= 1'b1;
      end else if (stepping_q && last) begin
        stepping_q <= 1'b0;
      end
    end
  end

  // walking datapath
  always_ff @(posedge clk) begin
    if (seg.load) begin
      cur_q       <= seg.p0.norm;
      end_major_q <= seg.p1.norm.major;
      dmaj_q      <= dmaj_in;
      dmin_q      <= dmin_in;
      err_q       <= err_in;
      neg_q       <= seg.negative;
      steep_q     <= seg.octant.steep;
    end else if (stepping_q) begin
      // undo the axis exchange on the way out
      pixel_x     <= steep_q ? cur_q.minor : cur_q.major;
      pixel_y     <= steep_q ? cur_q.major : cur_q.minor;
      cur_q.major <= cur_q.major + 1'b1;
      if (err_pos) begin
        // minor step drops the error by 2*(dmaj - dmin)
        cur_q.minor <= neg_q ? cur_q.minor - 1'b1 : cur_q.minor + 1'b1;
        err_q       <= err_q + {dmin_q - dmaj_q, 1'b0};
      end else begin
        err_q       <= err_q + {dmin_q, 1'b0};
      end
    end
  end

  assign seg.busy = busy_q;

  // pixels run back to back inside the busy window until done
  a_valid_in_busy: assert property (@(posedge clk) disable iff (rst)
    pixel_valid && !done |=> pixel_valid && seg.busy)
    else $error("pixel stream broken inside busy window");

  // done rides on the pixel at the far end of the major axis
  a_done_with_pixel: assert property (@(posedge clk) disable iff (rst)
    done |-> pixel_valid && (steep_q ? pixel_y : pixel_x) == end_major_q)
    else $error("done not on the last pixel");

endmodule

// ==== hw/line_draw.sv ====
`include "line_defs.svh"

// Bresenham line rasterizer
// start sampled at edge 0, segment loaded at edge 1
// first pixel after edge 2, then one per cycle for N+1 pixels
// done rides on the last pixel, busy drops one edge later
module line_draw (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic [`COORD_W-1:0] x0,
  input  logic [`COORD_W-1:0] y0,
  input  logic [`COORD_W-1:0] x1,
  input  logic [`COORD_W-1:0] y1,
  output logic                busy,
  output logic                pixel_valid,
  output logic [`COORD_W-1:0] pixel_x,
  output logic [`COORD_W-1:0] pixel_y,
  output logic                done
);

  // normalized segment from setup to stepper
  line_seg_if seg ();

  // registers endpoints and normalizes into the first octant
  line_setup u_setup (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .x0    (x0),
    .y0    (y0),
    .x1    (x1),
    .y1    (y1),
    .seg   (seg.source)
  );

  // walks the major axis and maps back to screen space
  bresenham_stepper u_stepper (
    .clk         (clk),
    .rst         (rst),
    .seg         (seg.sink),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .done        (done)
  );

  // starts arriving while this is high are dropped
  assign busy = seg.busy;

endmodule

// ==== verif/line_draw_tb.sv ====
`include "line_defs.svh"

module line_draw_tb;

  // longest line is 1024 pixels plus setup latency
  localparam int WAIT_LIMIT = 2500;
  localparam int COORD_MAX  = 1 << `COORD_W;

  logic                clk;
  logic                rst;
  logic                start;
  logic [`COORD_W-1:0] x0;
  logic [`COORD_W-1:0] y0;
  logic [`COORD_W-1:0] x1;
  logic [`COORD_W-1:0] y1;
  logic                busy;
  logic                pixel_valid;
  logic [`COORD_W-1:0] pixel_x;
  logic [`COORD_W-1:0] pixel_y;
  logic                done;

  // marks the start that opens a line
  // stray starts leave it low
  logic line_start;

  int timing_errs;
  int pixel_errs;
  int hang_errs;
  int lines_started;
  int lines_done;

  // expected line captured at the edge that samples start
  logic active;
  int   age;
  int   lx0;
  int   ly0;
  int   lx1;
  int   ly1;
  int   n_len;
  logic l_steep;
  // pixels seen so far on this line
  int   pix_cnt;
  int   first_x;
  int   first_y;
  int   prev_x;
  int   prev_y;

  logic exp_busy;
  logic exp_valid;
  logic exp_done;
  logic first_ok;
  logic step_ok;
  logic near_ok;
  logic ends_ok;

  line_draw DUT (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .x0          (x0),
    .y0          (y0),
    .x1          (x1),
    .y1          (y1),
    .busy        (busy),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .done        (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      active     <= 1'b0;
      age        <= 0;
      pix_cnt    <= 0;
      lines_done <= 0;
    end else begin
      if (start && line_start) begin
        active  <= 1'b1;
        age     <= 0;
        lx0     <= x0;
        ly0     <= y0;
        lx1     <= x1;
        ly1     <= y1;
        // N is the larger delta and ties count as shallow
        n_len   <= (abs_int(int'(x1) - int'(x0)) >= abs_int(int'(y1) - int'(y0))) ?
                   abs_int(int'(x1) - int'(x0)) : abs_int(int'(y1) - int'(y0));
        l_steep <= abs_int(int'(y1) - int'(y0)) > abs_int(int'(x1) - int'(x0));
        pix_cnt <= 0;
      end else if (active) begin
        age <= age + 1;
        // busy drops at edge N+3
        if (age == n_len + 2) begin
          active <= 1'b0;
        end
      end
      if (pixel_valid) begin
        pix_cnt <= pix_cnt + 1;
        if (pix_cnt == 0) begin
          first_x <= pixel_x;
          first_y <= pixel_y;
        end
        prev_x <= pixel_x;
        prev_y <= pixel_y;
      end
      if (done) begin
        lines_done <= lines_done + 1;
      end
    end
  end

  // busy from edge 1 and pixels from edge 2 up to the last one at edge N+2
  assign exp_busy  = active && age >= 1;
  assign exp_valid = active && age >= 2;
  assign exp_done  = active && age == n_len + 2;

  always_comb begin
    int   px;
    int   py;
    int   fx;
    int   fy;
    int   mx;
    int   my;
    int   cross_prod;
    logic at_end0;
    logic at_end1;
    px = int'(pixel_x);
    py = int'(pixel_y);
    // a single-point line has no stored first pixel yet
    fx = (pix_cnt == 0) ? px : first_x;
    fy = (pix_cnt == 0) ? py : first_y;
    mx = abs_int(px - prev_x);
    my = abs_int(py - prev_y);
    // cross product against the ideal line through both endpoints
    cross_prod = (px - lx0) * (ly1 - ly0) - (py - ly0) * (lx1 - lx0);
    at_end0    = px == lx0 && py == ly0;
    at_end1    = px == lx1 && py == ly1;
    first_ok   = at_end0 || at_end1;
    step_ok    = l_steep ? (my == 1 && mx <= 1) : (mx == 1 && my <= 1);
    near_ok    = 2 * abs_int(cross_prod) <= n_len;
    ends_ok    = (fx == lx0 && fy == ly0 && at_end1) || (fx == lx1 && fy == ly1 && at_end0);
  end

  a_busy_window: assert property (@(posedge clk) disable iff (rst) busy == exp_busy)
    else begin
      timing_errs++;
      $display("Error at %0t: busy level wrong in line cycle %0d", $time, age);
    end

  a_valid_window: assert property (@(posedge clk) disable iff (rst) pixel_valid == exp_valid)
    else begin
      timing_errs++;
      $display("Error at %0t: pixel_valid wrong in line cycle %0d", $time, age);
    end

  a_done_last: assert property (@(posedge clk) disable iff (rst) done == exp_done)
    else begin
      timing_errs++;
      $display("Error at %0t: done wrong in line cycle %0d", $time, age);
    end

  a_pixel_count: assert property (@(posedge clk) disable iff (rst) done |-> pix_cnt == n_len)
    else begin
      timing_errs++;
      $display("Error at %0t: line ended after %0d pixels, N is %0d", $time, pix_cnt + 1, n_len);
    end

  a_first_endpoint: assert property (@(posedge clk) disable iff (rst)
    pixel_valid && pix_cnt == 0 |-> first_ok)
    else begin
      pixel_errs++;
      $display("Error at %0t: first pixel is not an endpoint", $time);
    end

  a_last_endpoint: assert property (@(posedge clk) disable iff (rst) done |-> ends_ok)
    else begin
      pixel_errs++;
      $display("Error at %0t: last pixel is not the opposite endpoint", $time);
    end

  a_step: assert property (@(posedge clk) disable iff (rst)
    pixel_valid && pix_cnt != 0 |-> step_ok)
    else begin
      pixel_errs++;
      $display("Error at %0t: pixel step from (%0d,%0d) is broken", $time, prev_x, prev_y);
    end

  a_near_line: assert property (@(posedge clk) disable iff (rst) pixel_valid |-> near_ok)
    else begin
      pixel_errs++;
      $display("Error at %0t: pixel more than half a unit off the line", $time);
    end

  // polls busy one unit after each edge until it reaches level
  task automatic wait_for_busy(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (busy !== level && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (busy !== level) begin
      hang_errs++;
      $display("hang: %s within %0d cycles", what, WAIT_LIMIT);
    end
  endtask

  // one line with optional stray starts while busy
  task automatic draw_line(input int ax, input int ay, input int bx, input int by,
                           input bit stray);
    int cycles;
    if (hang_errs != 0) begin
      return;
    end
    wait_for_busy(1'b0, "busy did not drop before a new line");
    x0         = ax;
    y0         = ay;
    x1         = bx;
    y1         = by;
    start      = 1'b1;
    line_start = 1'b1;
    lines_started++;
    @(posedge clk);
    #1;
    start      = 1'b0;
    line_start = 1'b0;
    wait_for_busy(1'b1, "busy did not rise after start");
    cycles = 0;
    while (busy && cycles < WAIT_LIMIT) begin
      // busy is still high at the next edge so this start is dropped
      if (stray && ($urandom % 4 == 0)) begin
        x0    = $urandom % COORD_MAX;
        y0    = $urandom % COORD_MAX;
        x1    = $urandom % COORD_MAX;
        y1    = $urandom % COORD_MAX;
        start = 1'b1;
      end
      @(posedge clk);
      #1;
      start = 1'b0;
      cycles++;
    end
    if (busy) begin
      hang_errs++;
      $display("hang: line from (%0d,%0d) to (%0d,%0d) never finished", ax, ay, bx, by);
    end
  endtask

  task automatic random_line();
    int ax;
    int ay;
    int bx;
    int by;
    ax = $urandom % COORD_MAX;
    ay = $urandom % COORD_MAX;
    if ($urandom % 3 == 0) begin
      // short line around the first endpoint that wraps at the frame edge
      bx = (ax + COORD_MAX - 12 + $urandom % 25) % COORD_MAX;
      by = (ay + COORD_MAX - 12 + $urandom % 25) % COORD_MAX;
    end else begin
      bx = $urandom % COORD_MAX;
      by = $urandom % COORD_MAX;
    end
    draw_line(ax, ay, bx, by, 1'b1);
  endtask

  initial begin
    void'($urandom(9870));
    timing_errs   = 0;
    pixel_errs    = 0;
    hang_errs     = 0;
    lines_started = 0;
    rst        = 1'b1;
    start      = 1'b0;
    line_start = 1'b0;
    x0         = '0;
    y0         = '0;
    x1         = '0;
    y1         = '0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    // idle stretch with all outputs low
    repeat (12) @(posedge clk);
    #1;
    // all eight octants
    draw_line(100, 100, 200, 150, 1'b0);
    draw_line(200, 150, 100, 100, 1'b0);
    draw_line(100, 150, 200, 100, 1'b0);
    draw_line(200, 100, 100, 150, 1'b1);
    draw_line(100, 100, 150, 200, 1'b0);
    draw_line(150, 200, 100, 100, 1'b0);
    draw_line(150, 100, 100, 200, 1'b1);
    draw_line(100, 200, 150, 100, 1'b0);
    // axis aligned lines and diagonals then a single point and the full frame
    draw_line(10, 20, 40, 20, 1'b0);
    draw_line(40, 20, 10, 20, 1'b0);
    draw_line(30, 5, 30, 45, 1'b0);
    draw_line(30, 45, 30, 5, 1'b1);
    draw_line(0, 0, 25, 25, 1'b0);
    draw_line(50, 10, 20, 40, 1'b0);
    draw_line(7, 7, 7, 7, 1'b0);
    draw_line(0, 1023, 1023, 0, 1'b1);
    for (int i = 0; i < 200; i++) begin
      random_line();
    end
    repeat (4) @(posedge clk);
    if (lines_done != lines_started) begin
      timing_errs++;
      $display("Error at %0t: %0d lines started, %0d finished", $time, lines_started,
               lines_done);
    end
    $display("line_draw_tb: %0d timing errors, %0d pixel errors, %0d hangs",
             timing_errs, pixel_errs, hang_errs);
    if (timing_errs + pixel_errs + hang_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== line_draw.f ====
+incdir+hw
hw/line_pkg.sv
hw/line_seg_if.sv
hw/point_swapper.sv
hw/line_setup.sv
hw/bresenham_stepper.sv
hw/line_draw.sv
verif/line_draw_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the line rasterizer testbench with Verilator and run it
# the log decides pass or fail

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module line_draw_tb -f line_draw.f; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vline_draw_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  exit 1
fi

exit 0
